// File: files.f
+incdir+source
source/dbg_pkg.sv
source/dbg_cmd_if.sv
source/skid_buffer.sv
source/dbg_write_channel.sv
source/dbg_read_channel.sv
source/cpu_cmd_ctrl.sv
source/zip_dbg_axil.sv
test/tb_zip_dbg_axil.sv

// File: run_sim.sh
#!/bin/bash
# Build and run the debug wrapper testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f \
	--top-module tb_zip_dbg_axil -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Test completed successfully" sim.log; then
	exit 0
else
	exit 1
fi

// File: source/cpu_cmd_ctrl.sv
// CPU reset hold, halt/step/reset/clear-cache commands and status word
// Break handling follows the start-halted setting
`timescale 1ns/1ns
`default_nettype none

`include "dbg_defines.svh"

module cpu_cmd_ctrl
	import dbg_pkg::*;
(
	input	wire			S_AXI_ACLK,
	input	wire			S_AXI_ARESETN,

	input	wire			i_cpu_reset,
	input	wire			i_interrupt,

	// From the core
	input	wire			i_dbg_stall,
	input	wire			i_break,
	input	wire [2:0]		i_dbg_cc,

	dbg_cmd_if.dst			cmd,

	// To the core
	output	logic			o_cmd_reset,
	output	logic			o_halt,
	output	logic			o_clear_cache,

	output	cpu_status_t		o_status
);

	// Core runs from reset; a break resets it
	localparam logic START_HALTED = 1'b0;
	localparam int RST_CNT_W = $clog2(`DBG_RESET_DURATION + 1);

	logic [RST_CNT_W-1:0]	rst_count;
	logic			hold_active;
	logic			cmd_step;
	logic			wr_halt;
	logic			wr_step;
	logic			wr_clear;
	logic			wr_reset;

	// Decoded control write, byte 0 for reset, byte 1 for the rest
	assign wr_reset = cmd.cmd_write && cmd.wstrb[`RESET_BIT/8]
		&& cmd.wdata[`RESET_BIT];
	assign wr_halt = cmd.cmd_write && cmd.wstrb[`HALT_BIT/8]
		&& cmd.wdata[`HALT_BIT];
	assign wr_step = cmd.cmd_write && cmd.wstrb[`STEP_BIT/8]
		&& cmd.wdata[`STEP_BIT];
	assign wr_clear = cmd.cmd_write && cmd.wstrb[`CLEAR_CACHE_BIT/8]
		&& cmd.wdata[`CLEAR_CACHE_BIT];

	//////////////////////////////////////////////////////////////////////
	// Reset hold
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			rst_count <= RST_CNT_W'(`DBG_RESET_DURATION);
		else if (rst_count != '0)
			rst_count <= rst_count - 1'b1;
	end

	// Counter still above one keeps the reset for the next cycle
	assign hold_active = (rst_count > RST_CNT_W'(1));

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			o_cmd_reset <= 1'b1;
		else if (hold_active)
			o_cmd_reset <= 1'b1;
		else if (i_break && !START_HALTED)
			o_cmd_reset <= 1'b1;
		else
			o_cmd_reset <= wr_reset;
	end

	//////////////////////////////////////////////////////////////////////
	// Halt, step and clear cache
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_halt <= START_HALTED;
		else if (i_cpu_reset && !cmd.reg_write)
			o_halt <= START_HALTED;
		else if (o_cmd_reset && START_HALTED)
			o_halt <= START_HALTED;
		else
		begin
			// Resume, once the core is idle and no write is pending
			if (!cmd.write_busy && !i_dbg_stall && cmd.cmd_write
				&& cmd.wstrb[`HALT_BIT/8]
				&& (!cmd.wdata[`HALT_BIT] || cmd.wdata[`STEP_BIT]))
				o_halt <= 1'b0;

			// Later rules win over the resume
			if (i_break && START_HALTED)
				o_halt <= 1'b1;
			if (wr_halt && !cmd.wdata[`STEP_BIT])
				o_halt <= 1'b1;
			// Register writes need a stopped core
			if (cmd.reg_write)
				o_halt <= 1'b1;
			// Single step done
			if (cmd_step)
				o_halt <= 1'b1;
			if (o_clear_cache || wr_clear)
				o_halt <= 1'b1;
		end
	end

	// Step pulse lasts until the core takes it
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			cmd_step <= 1'b0;
		else if (wr_step)
			cmd_step <= 1'b1;
		else if (!i_dbg_stall)
			cmd_step <= 1'b0;
	end

	// Clear cache only together with halt
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || o_cmd_reset)
			o_clear_cache <= 1'b0;
		else if (wr_clear && cmd.wdata[`HALT_BIT])
			o_clear_cache <= 1'b1;
		else if (o_halt && !i_dbg_stall)
			o_clear_cache <= 1'b0;
	end

	//////////////////////////////////////////////////////////////////////
	// Status word
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		o_status = '0;
		o_status.reset = o_cmd_reset;
		o_status.intr_pend = i_interrupt;
		// Not stalled counts as halted
		o_status.halted = !i_dbg_stall;
		o_status.halt_cmd = o_halt;
		o_status.cc = i_dbg_cc;
		o_status.brk = i_break;
		o_status.intr = i_interrupt;
	end

endmodule

`default_nettype wire

// File: source/dbg_cmd_if.sv
// Accepted debug writes, from the write channel to the command controller
`timescale 1ns/1ns
`default_nettype none

`include "dbg_defines.svh"

interface dbg_cmd_if;

	// Single cycle strobes, no handshake back
	logic				cmd_write;
	logic				reg_write;

	// Word and strobes of the accepted write
	logic [`DBG_DATA_W-1:0]		wdata;
	logic [`DBG_DATA_W/8-1:0]	wstrb;

	// Core write still waiting on the stall
	logic				write_busy;

	modport src (
		output	cmd_write, reg_write, wdata, wstrb, write_busy
	);

	modport dst (
		input	cmd_write, reg_write, wdata, wstrb, write_busy
	);

endinterface

`default_nettype wire

// File: source/dbg_defines.svh
// Debug port widths, address map bits and command bit positions
// Reset hold length for the CPU
`ifndef DBG_DEFINES_SVH
`define DBG_DEFINES_SVH

// Debug bus is a single 32-bit word
`define DBG_DATA_W		32

// Byte address width of the debug port
`define DBG_ADDR_W		8

// Byte offset bits dropped to form a word address
`define DBG_LSB			2

// Word address bit selecting the control word over the register file
`define DBG_CTRL_BIT		5

// Command bits within a control write
`define RESET_BIT		6
`define STEP_BIT		8
`define HALT_BIT		10
`define CLEAR_CACHE_BIT		11

// Cycles of CPU reset after power on or an external CPU reset
`define DBG_RESET_DURATION	10

`endif

// File: source/dbg_pkg.sv
// Shared types for the debug wrapper
// Word addresses, register numbers, write payload and status word
`default_nettype none

`include "dbg_defines.svh"

package dbg_pkg;

	// Byte address with the offset bits stripped
	typedef logic [`DBG_ADDR_W-`DBG_LSB-1:0] word_addr_t;

	// One of the 32 CPU registers
	typedef logic [`DBG_CTRL_BIT-1:0] reg_id_t;

	// W channel contents, data above strobes
	typedef struct packed {
		logic [`DBG_DATA_W-1:0]		data;
		logic [`DBG_DATA_W/8-1:0]	strb;
	} wr_payload_t;

	// Status word, listed MSB first
	typedef struct packed {
		logic [14:0]	zero_hi;
		logic		intr;
		logic		brk;
		logic [2:0]	cc;
		logic		zero_11;
		logic		halt_cmd;
		logic		halted;
		logic		zero_8;
		logic		intr_pend;
		logic		reset;
		logic [5:0]	zero_lo;
	} cpu_status_t;

endpackage

`default_nettype wire

// File: source/dbg_read_channel.sv
// AXI-lite AR handling, CPU register read forwarding and R data select
`timescale 1ns/1ns
`default_nettype none

`include "dbg_defines.svh"

module dbg_read_channel
	import dbg_pkg::*;
(
	input	wire			S_AXI_ACLK,
	input	wire			S_AXI_ARESETN,

	// AR channel
	input	wire			i_arvalid,
	output	logic			o_arready,
	input	wire word_addr_t	i_araddr,

	// R channel
	output	logic			o_rvalid,
	input	wire			i_rready,
	output	logic [`DBG_DATA_W-1:0]	o_rdata,

	// Status word from the command controller
	input	wire cpu_status_t	i_status,

	// CPU debug read port
	output	reg_id_t		o_dbg_rreg,
	input	wire [`DBG_DATA_W-1:0]	i_dbg_rdata
);

	word_addr_t	ar_addr;
	logic		ar_valid;
	logic		read_ready;
	logic		rd_pending;
	logic		ctrl_sel;

	skid_buffer #(.T(word_addr_t)) ar_skid_inst (
		.S_AXI_ACLK	(S_AXI_ACLK),
		.S_AXI_ARESETN	(S_AXI_ARESETN),
		.i_valid	(i_arvalid),
		.o_ready	(o_arready),
		.i_data		(i_araddr),
		.o_valid	(ar_valid),
		.i_ready	(read_ready),
		.o_data		(ar_addr)
	);

	// Control region decode
	assign ctrl_sel = ar_addr[`DBG_CTRL_BIT];

	// One read at a time, and only into a free R slot
	assign read_ready = ar_valid && !rd_pending && (!o_rvalid || i_rready);

	// Register number goes out on the accept cycle
	assign o_dbg_rreg = ar_addr[`DBG_CTRL_BIT-1:0];

	// Core data arrives the cycle after
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rd_pending <= 1'b0;
		else
			rd_pending <= read_ready && !ctrl_sel;
	end

	// Status reads answer at once, register reads one cycle later
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_rvalid <= 1'b0;
		else if (!o_rvalid || i_rready)
			o_rvalid <= (read_ready && ctrl_sel) || rd_pending;
	end

	// R data select
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!o_rvalid || i_rready)
		begin
			if (rd_pending)
				o_rdata <= i_dbg_rdata;
			else
				o_rdata <= i_status;
		end
	end

endmodule

`default_nettype wire

// File: source/dbg_write_channel.sv
// AXI-lite AW/W join, CPU register write forwarding and B response
// Control region writes leave as a command pulse
`timescale 1ns/1ns
`default_nettype none

`include "dbg_defines.svh"

module dbg_write_channel
	import dbg_pkg::*;
(
	input	wire			S_AXI_ACLK,
	input	wire			S_AXI_ARESETN,

	// AW channel
	input	wire			i_awvalid,
	output	logic			o_awready,
	input	wire word_addr_t	i_awaddr,

	// W channel
	input	wire			i_wvalid,
	output	logic			o_wready,
	input	wire wr_payload_t	i_wdata,

	// B channel
	output	logic			o_bvalid,
	input	wire			i_bready,

	// CPU debug write port
	input	wire			i_dbg_stall,
	output	logic			o_dbg_we,
	output	reg_id_t		o_dbg_wreg,
	output	logic [`DBG_DATA_W-1:0]	o_dbg_wdata,

	dbg_cmd_if.src			cmd
);

	word_addr_t	aw_addr;
	wr_payload_t	w_data;
	logic		aw_valid;
	logic		w_valid;
	logic		write_ready;
	logic		write_stall;
	logic		reg_accept;
	logic		ctrl_sel;

	//////////////////////////////////////////////////////////////////////
	// Skid buffers
	//////////////////////////////////////////////////////////////////////

	skid_buffer #(.T(word_addr_t)) aw_skid_inst (
		.S_AXI_ACLK	(S_AXI_ACLK),
		.S_AXI_ARESETN	(S_AXI_ARESETN),
		.i_valid	(i_awvalid),
		.o_ready	(o_awready),
		.i_data		(i_awaddr),
		.o_valid	(aw_valid),
		.i_ready	(write_ready),
		.o_data		(aw_addr)
	);

	skid_buffer #(.T(wr_payload_t)) w_skid_inst (
		.S_AXI_ACLK	(S_AXI_ACLK),
		.S_AXI_ARESETN	(S_AXI_ARESETN),
		.i_valid	(i_wvalid),
		.o_ready	(o_wready),
		.i_data		(i_wdata),
		.o_valid	(w_valid),
		.i_ready	(write_ready),
		.o_data		(w_data)
	);

	//////////////////////////////////////////////////////////////////////
	// Accept and route
	//////////////////////////////////////////////////////////////////////

	assign ctrl_sel = aw_addr[`DBG_CTRL_BIT];

	// Core still holding the last register write
	assign write_stall = o_dbg_we && i_dbg_stall;

	// Both halves present, B free, and somewhere to put the data
	assign write_ready = aw_valid && w_valid
		&& (!o_bvalid || i_bready)
		&& ((w_data.strb == '0) || ctrl_sel || !write_stall);

	// Empty strobes are acknowledged and dropped
	assign reg_accept = write_ready && (|w_data.strb) && !ctrl_sel;

	// Core write strobe, held through the stall
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_dbg_we <= 1'b0;
		else if (!write_stall)
			o_dbg_we <= reg_accept;
	end

	// Register number and data, frozen while stalled
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!write_stall)
		begin
			o_dbg_wreg <= aw_addr[`DBG_CTRL_BIT-1:0];
			o_dbg_wdata <= w_data.data;
		end
	end

	// One B per accepted pair
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_bvalid <= 1'b0;
		else if (write_ready)
			o_bvalid <= 1'b1;
		else if (i_bready)
			o_bvalid <= 1'b0;
	end

	// To the command controller
	assign cmd.cmd_write = write_ready && ctrl_sel;
	assign cmd.reg_write = reg_accept;
	assign cmd.wdata = w_data.data;
	assign cmd.wstrb = w_data.strb;
	assign cmd.write_busy = o_dbg_we;

endmodule

`default_nettype wire

// File: source/skid_buffer.sv
// Valid/ready skid buffer with a type parameter payload
// Holds one item on the wire and one in the side register
`timescale 1ns/1ns
`default_nettype none

module skid_buffer
	import dbg_pkg::*;
#(
	parameter type T = word_addr_t
) (
	input	wire		S_AXI_ACLK,
	input	wire		S_AXI_ARESETN,

	// Upstream side
	input	wire		i_valid,
	output	logic		o_ready,
	input	wire T		i_data,

	// Downstream side
	output	logic		o_valid,
	input	wire		i_ready,
	output	T		o_data
);

	// Side register
	logic	r_valid;
	T	r_data;

	// Fill when an item arrives that downstream refuses
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_valid <= 1'b0;
		else if (i_valid && o_ready && !i_ready)
			r_valid <= 1'b1;
		else if (i_ready)
			r_valid <= 1'b0;
	end

	// Capture whatever is on the wire while empty
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
			r_data <= i_data;
	end

	// Ready only while the side register is free
	assign o_ready = !r_valid;

	// Stored item goes first
	assign o_valid = i_valid || r_valid;
	assign o_data = r_valid ? r_data : i_data;

endmodule

`default_nettype wire

// File: source/zip_dbg_axil.sv
// Debug control wrapper top level
// AXI-lite slave port to the CPU debug port and control word
`timescale 1ns/1ns
`default_nettype none

`include "dbg_defines.svh"

module zip_dbg_axil
	import dbg_pkg::*;
(
	input	wire				S_AXI_ACLK,
	input	wire				S_AXI_ARESETN,
	input	wire				i_interrupt,
	input	wire				i_cpu_reset,

	// AXI-lite debug slave
	input	wire				i_s_dbg_awvalid,
	output	logic				o_s_dbg_awready,
	input	wire [`DBG_ADDR_W-1:0]		i_s_dbg_awaddr,
	input	wire				i_s_dbg_wvalid,
	output	logic				o_s_dbg_wready,
	input	wire [`DBG_DATA_W-1:0]		i_s_dbg_wdata,
	input	wire [`DBG_DATA_W/8-1:0]	i_s_dbg_wstrb,
	output	logic				o_s_dbg_bvalid,
	input	wire				i_s_dbg_bready,
	output	logic [1:0]			o_s_dbg_bresp,
	input	wire				i_s_dbg_arvalid,
	output	logic				o_s_dbg_arready,
	input	wire [`DBG_ADDR_W-1:0]		i_s_dbg_araddr,
	output	logic				o_s_dbg_rvalid,
	input	wire				i_s_dbg_rready,
	output	logic [`DBG_DATA_W-1:0]		o_s_dbg_rdata,
	output	logic [1:0]			o_s_dbg_rresp,

	// CPU debug port
	output	logic				o_cmd_reset,
	output	logic				o_halt,
	output	logic				o_clear_cache,
	output	logic				o_dbg_we,
	output	reg_id_t			o_dbg_wreg,
	output	logic [`DBG_DATA_W-1:0]		o_dbg_wdata,
	output	reg_id_t			o_dbg_rreg,
	input	wire				i_dbg_stall,
	input	wire				i_break,
	input	wire [2:0]			i_dbg_cc,
	input	wire [`DBG_DATA_W-1:0]		i_dbg_rdata
);

	word_addr_t	aw_word;
	word_addr_t	ar_word;
	wr_payload_t	w_payload;
	cpu_status_t	status;

	dbg_cmd_if cmd_bus ();

	// Word addresses, byte offset dropped
	assign aw_word = i_s_dbg_awaddr[`DBG_ADDR_W-1:`DBG_LSB];
	assign ar_word = i_s_dbg_araddr[`DBG_ADDR_W-1:`DBG_LSB];
	assign w_payload = '{data: i_s_dbg_wdata, strb: i_s_dbg_wstrb};

	// Always OKAY
	assign o_s_dbg_bresp = 2'b00;
	assign o_s_dbg_rresp = 2'b00;

	dbg_write_channel dbg_write_channel_inst (
		.S_AXI_ACLK	(S_AXI_ACLK),
		.S_AXI_ARESETN	(S_AXI_ARESETN),
		.i_awvalid	(i_s_dbg_awvalid),
		.o_awready	(o_s_dbg_awready),
		.i_awaddr	(aw_word),
		.i_wvalid	(i_s_dbg_wvalid),
		.o_wready	(o_s_dbg_wready),
		.i_wdata	(w_payload),
		.o_bvalid	(o_s_dbg_bvalid),
		.i_bready	(i_s_dbg_bready),
		.i_dbg_stall	(i_dbg_stall),
		.o_dbg_we	(o_dbg_we),
		.o_dbg_wreg	(o_dbg_wreg),
		.o_dbg_wdata	(o_dbg_wdata),
		.cmd		(cmd_bus.src)
	);

	dbg_read_channel dbg_read_channel_inst (
		.S_AXI_ACLK	(S_AXI_ACLK),
		.S_AXI_ARESETN	(S_AXI_ARESETN),
		.i_arvalid	(i_s_dbg_arvalid),
		.o_arready	(o_s_dbg_arready),
		.i_araddr	(ar_word),
		.o_rvalid	(o_s_dbg_rvalid),
		.i_rready	(i_s_dbg_rready),
		.o_rdata	(o_s_dbg_rdata),
		.i_status	(status),
		.o_dbg_rreg	(o_dbg_rreg),
		.i_dbg_rdata	(i_dbg_rdata)
	);

	cpu_cmd_ctrl cpu_cmd_ctrl_inst (
		.S_AXI_ACLK	(S_AXI_ACLK),
		.S_AXI_ARESETN	(S_AXI_ARESETN),
		.i_cpu_reset	(i_cpu_reset),
		.i_interrupt	(i_interrupt),
		.i_dbg_stall	(i_dbg_stall),
		.i_break	(i_break),
		.i_dbg_cc	(i_dbg_cc),
		.cmd		(cmd_bus.dst),
		.o_cmd_reset	(o_cmd_reset),
		.o_halt		(o_halt),
		.o_clear_cache	(o_clear_cache),
		.o_status	(status)
	);

endmodule

`default_nettype wire

// File: test/tb_zip_dbg_axil.sv
// Testbench for the debug control wrapper
// Core model, AXI-lite driver tasks, back-pressure and checks
`timescale 1ns/1ns
`default_nettype none

module tb_zip_dbg_axil;

	localparam int TIMEOUT = 400;
	localparam logic [7:0] CTRL_ADDR = 8'h80;

	logic		clk;
	logic		arstn;
	logic		i_interrupt, i_cpu_reset;
	logic		awvalid, wvalid, bready, arvalid, rready;
	logic [7:0]	awaddr, araddr;
	logic [31:0]	wdata;
	logic [3:0]	wstrb;
	wire		awready, wready, bvalid, arready, rvalid;
	wire [1:0]	bresp, rresp;
	wire [31:0]	rdata;
	wire		o_cmd_reset, o_halt, o_clear_cache, o_dbg_we;
	wire [4:0]	o_dbg_wreg, o_dbg_rreg;
	wire [31:0]	o_dbg_wdata;
	logic		i_dbg_stall, i_break;
	logic [2:0]	i_dbg_cc;
	logic [31:0]	i_dbg_rdata;

	integer		seed = 77;
	int		errors = 0;
	int		checks = 0;
	int		test_start = 0;
	logic		hung = 1'b0;
	logic		bp_on = 1'b0;
	logic		halt_dly;
	logic		prev_halt, prev_reset, prev_clear;
	int		halt_falls = 0, halt_rises = 0, reset_rises = 0, clear_rises = 0;
	logic [31:0]	core_regs [32];
	logic [31:0]	exp_regs [32];

	zip_dbg_axil zip_dbg_axil_inst (
		.S_AXI_ACLK(clk), .S_AXI_ARESETN(arstn),
		.i_interrupt(i_interrupt), .i_cpu_reset(i_cpu_reset),
		.i_s_dbg_awvalid(awvalid), .o_s_dbg_awready(awready),
		.i_s_dbg_awaddr(awaddr), .i_s_dbg_wvalid(wvalid),
		.o_s_dbg_wready(wready), .i_s_dbg_wdata(wdata),
		.i_s_dbg_wstrb(wstrb), .o_s_dbg_bvalid(bvalid),
		.i_s_dbg_bready(bready), .o_s_dbg_bresp(bresp),
		.i_s_dbg_arvalid(arvalid), .o_s_dbg_arready(arready),
		.i_s_dbg_araddr(araddr), .o_s_dbg_rvalid(rvalid),
		.i_s_dbg_rready(rready), .o_s_dbg_rdata(rdata),
		.o_s_dbg_rresp(rresp), .o_cmd_reset(o_cmd_reset),
		.o_halt(o_halt), .o_clear_cache(o_clear_cache),
		.o_dbg_we(o_dbg_we), .o_dbg_wreg(o_dbg_wreg),
		.o_dbg_wdata(o_dbg_wdata), .o_dbg_rreg(o_dbg_rreg),
		.i_dbg_stall(i_dbg_stall), .i_break(i_break),
		.i_dbg_cc(i_dbg_cc), .i_dbg_rdata(i_dbg_rdata)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] rand_word();
		logic [31:0] r;
		r = $random(seed);
		return r;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Core model and back-pressure
	//////////////////////////////////////////////////////////////////////

	// Register file, read data one cycle after the register number
	always @(posedge clk)
	begin
		i_dbg_rdata <= core_regs[o_dbg_rreg];
		if (o_dbg_we && !i_dbg_stall)
			core_regs[o_dbg_wreg] <= o_dbg_wdata;
	end

	// Random stall while running, quiet two cycles into a halt
	always @(posedge clk)
	begin
		logic [31:0] r;
		r = rand_word();
		halt_dly <= o_halt;
		i_dbg_stall <= (o_halt && halt_dly) ? 1'b0 : r[0];
	end

	always @(posedge clk)
	begin
		logic [31:0] r;
		r = rand_word();
		bready <= bp_on ? r[0] : 1'b1;
		rready <= bp_on ? r[1] : 1'b1;
	end

	// Edge counters for halt, reset and clear cache pulses
	always @(negedge clk)
	begin
		if (prev_halt && !o_halt)
			halt_falls <= halt_falls + 1;
		if (!prev_halt && o_halt)
			halt_rises <= halt_rises + 1;
		if (!prev_reset && o_cmd_reset)
			reset_rises <= reset_rises + 1;
		if (!prev_clear && o_clear_cache)
			clear_rises <= clear_rises + 1;
		prev_halt <= o_halt;
		prev_reset <= o_cmd_reset;
		prev_clear <= o_clear_cache;
	end

	initial
	begin
		wait (hung);
		$display("Test failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Checks and driver tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic note_timeout(input string what);
		$display("Timeout at %0t while waiting for %s", $time, what);
		errors++;
		hung = 1'b1;
	endtask

	task automatic end_test(input string name);
		$display("%s: %0d errors", name, errors - test_start);
		test_start = errors;
	endtask

	// Status word built from the documented bit positions
	function automatic logic [31:0] status_word(input logic rst, input logic intr,
		input logic halted, input logic halt, input logic [2:0] cc, input logic brk);
		logic [31:0] s;
		s = '0;
		s[6] = rst;
		s[7] = intr;
		s[9] = halted;
		s[10] = halt;
		s[14:12] = cc;
		s[15] = brk;
		s[16] = intr;
		return s;
	endfunction

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		logic aw_done, w_done, a_hit, w_hit;
		int t;
		aw_done = 1'b0;
		w_done = 1'b0;
		t = 0;
		@(posedge clk);
		awvalid <= 1'b1;
		awaddr <= addr;
		wvalid <= 1'b1;
		wdata <= data;
		wstrb <= strb;
		while (!(aw_done && w_done) && t < TIMEOUT)
		begin
			@(negedge clk);
			a_hit = awvalid && awready;
			w_hit = wvalid && wready;
			@(posedge clk);
			if (a_hit)
			begin
				awvalid <= 1'b0;
				aw_done = 1'b1;
			end
			if (w_hit)
			begin
				wvalid <= 1'b0;
				w_done = 1'b1;
			end
			t++;
		end
		if (t >= TIMEOUT)
			note_timeout("AW/W handshake");
	endtask

	// Returns on the negedge of the B handshake cycle
	task automatic wait_b();
		int t;
		t = 0;
		while (t < TIMEOUT)
		begin
			@(negedge clk);
			if (bvalid && bready)
			begin
				check_val("o_s_dbg_bresp", bresp, 0);
				break;
			end
			t++;
		end
		if (t >= TIMEOUT)
			note_timeout("B response");
	endtask

	task automatic send_ar(input logic [7:0] addr);
		logic hit;
		int t;
		t = 0;
		hit = 1'b0;
		@(posedge clk);
		arvalid <= 1'b1;
		araddr <= addr;
		while (!hit && t < TIMEOUT)
		begin
			@(negedge clk);
			hit = arvalid && arready;
			@(posedge clk);
			if (hit)
				arvalid <= 1'b0;
			t++;
		end
		if (!hit)
			note_timeout("AR handshake");
	endtask

	task automatic recv_r(output logic [31:0] data);
		int t;
		t = 0;
		data = '0;
		while (t < TIMEOUT)
		begin
			@(negedge clk);
			if (rvalid && rready)
			begin
				data = rdata;
				check_val("o_s_dbg_rresp", rresp, 0);
				break;
			end
			t++;
		end
		if (t >= TIMEOUT)
			note_timeout("R response");
	endtask

	// Generic level wait on one of the watched DUT signals
	task automatic wait_level(input int which, input logic level, input string what);
		int t;
		logic v;
		t = 0;
		while (t < TIMEOUT)
		begin
			@(negedge clk);
			case (which)
				0: v = o_halt;
				1: v = o_cmd_reset;
				2: v = o_dbg_we;
				3: v = i_dbg_stall;
				default: v = o_clear_cache;
			endcase
			if (v == level)
				break;
			t++;
		end
		if (t >= TIMEOUT)
			note_timeout(what);
	endtask

	// Wait until one of the edge counters reaches a target
	task automatic wait_count(input int which, input int target, input string what);
		int t;
		int cnt;
		t = 0;
		cnt = 0;
		while (t < TIMEOUT)
		begin
			case (which)
				0: cnt = halt_rises;
				1: cnt = reset_rises;
				default: cnt = clear_rises;
			endcase
			if (cnt >= target)
				break;
			@(negedge clk);
			t++;
		end
		if (t >= TIMEOUT)
			note_timeout(what);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [31:0] d, got, mask;
		logic [4:0] r;
		logic [4:0] q_reg [$];
		int n, f0, r0, c0, bcount;

		arstn = 1'b0;
		i_interrupt = 1'b0;
		i_cpu_reset = 1'b0;
		awvalid = 1'b0;
		wvalid = 1'b0;
		arvalid = 1'b0;
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		wstrb = '0;
		bready = 1'b1;
		rready = 1'b1;
		i_dbg_stall = 1'b0;
		i_break = 1'b0;
		i_dbg_cc = 3'd5;
		i_dbg_rdata = '0;
		halt_dly = 1'b0;
		prev_halt = 1'b0;
		prev_reset = 1'b0;
		prev_clear = 1'b0;
		for (int i = 0; i < 32; i++)
		begin
			core_regs[i] = '0;
			exp_regs[i] = '0;
		end

		// 1: reset hold
		repeat (10) @(posedge clk);
		arstn <= 1'b1;
		n = 0;
		while (n < 50)
		begin
			@(negedge clk);
			if (!o_cmd_reset)
				break;
			n++;
		end
		check_val("o_cmd_reset cycles", n, 10);
		check_val("o_s_dbg_bvalid", bvalid, 0);
		check_val("o_s_dbg_rvalid", rvalid, 0);
		check_val("o_halt", o_halt, 0);
		check_val("o_clear_cache", o_clear_cache, 0);
		end_test("Test 1 reset hold");

		// 2: register write then read back
		repeat (8)
		begin
			d = rand_word();
			r = d[4:0];
			d = rand_word();
			axi_write({1'b0, r, 2'b00}, d, 4'hF);
			wait_b();
			wait_level(2, 1'b0, "core write");
			exp_regs[r] = d;
			check_val("o_halt", o_halt, 1);
			send_ar({1'b0, r, 2'b00});
			recv_r(got);
			check_val("o_s_dbg_rdata", got, exp_regs[r]);
		end
		end_test("Test 2 register access");

		// 3: resume, halt and resume again
		axi_write(CTRL_ADDR, 32'h0, 4'hF);
		wait_b();
		check_val("o_halt", o_halt, 0);
		axi_write(CTRL_ADDR, 32'h400, 4'hF);
		wait_b();
		check_val("o_halt", o_halt, 1);
		wait_level(3, 1'b0, "stall low");
		send_ar(CTRL_ADDR);
		recv_r(got);
		check_val("status", got, status_word(0, 0, 1, 1, i_dbg_cc, 0));
		axi_write(CTRL_ADDR, 32'h0, 4'hF);
		wait_b();
		check_val("o_halt", o_halt, 0);
		end_test("Test 3 halt command");

		// 4: single step, clear cache, then reset command
		axi_write(CTRL_ADDR, 32'h400, 4'hF);
		wait_b();
		wait_level(3, 1'b0, "stall low");
		f0 = halt_falls;
		r0 = halt_rises;
		axi_write(CTRL_ADDR, 32'h500, 4'hF);
		wait_b();
		wait_count(0, r0 + 1, "halt after step");
		check_val("o_halt falls", halt_falls, f0 + 1);
		// Clear cache goes with a halt
		c0 = clear_rises;
		axi_write(CTRL_ADDR, 32'hC00, 4'hF);
		wait_b();
		wait_count(2, c0 + 1, "clear cache pulse");
		wait_level(4, 1'b0, "clear cache release");
		c0 = reset_rises;
		axi_write(CTRL_ADDR, 32'h40, 4'h1);
		wait_b();
		wait_count(1, c0 + 1, "reset pulse");
		wait_level(1, 1'b0, "reset release");
		end_test("Test 4 step and reset");

		// 5: break while running
		wait_level(3, 1'b0, "stall low");
		axi_write(CTRL_ADDR, 32'h0, 4'hF);
		wait_b();
		check_val("o_halt", o_halt, 0);
		@(posedge clk);
		i_interrupt <= 1'b1;
		i_dbg_cc <= 3'd3;
		i_break <= 1'b1;
		wait_level(1, 1'b1, "reset on break");
		send_ar(CTRL_ADDR);
		recv_r(got);
		// Halted bit follows the random stall
		mask = ~32'h200;
		check_val("status", got & mask, status_word(1, 1, 0, 0, 3'd3, 1) & mask);
		@(posedge clk);
		i_break <= 1'b0;
		i_interrupt <= 1'b0;
		wait_level(1, 1'b0, "reset release");
		end_test("Test 5 break");

		// 6: pipelined traffic under back-pressure
		bp_on = 1'b1;
		bcount = 0;
		fork
			begin
				repeat (16)
				begin
					d = rand_word();
					r = d[4:0];
					d = rand_word();
					exp_regs[r] = d;
					q_reg.push_back(r);
					axi_write({1'b0, r, 2'b00}, d, 4'hF);
				end
			end
			begin
				int t;
				t = 0;
				while (bcount < 16 && t < TIMEOUT * 16)
				begin
					@(negedge clk);
					if (bvalid && bready)
						bcount++;
					t++;
				end
				if (bcount < 16)
					note_timeout("B responses");
			end
		join
		repeat (8)
		begin
			@(negedge clk);
			if (bvalid && bready)
				bcount++;
		end
		check_val("B count", bcount, 16);
		wait_level(2, 1'b0, "core write");
		check_val("o_halt", o_halt, 1);
		fork
			begin
				foreach (q_reg[i])
					send_ar({1'b0, q_reg[i], 2'b00});
			end
			begin
				foreach (q_reg[i])
				begin
					recv_r(got);
					check_val("o_s_dbg_rdata", got, exp_regs[q_reg[i]]);
				end
			end
		join
		bp_on = 1'b0;
		end_test("Test 6 back-pressure");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
